//--- bench/trace_golden.txt
// stimulus: instr pc rs1_value rs2_value wb_data cmpl_addr
// expected: op rd rd_we rd_value rs1 rs1_value rs2 rs2_value mem_addr
123452b7 100 a1 b2 12345000 d4 1 05 1 12345000 00 0 00 0 0
00000013 104 a1 b2 c3 d4 0 00 0 0 00 0 00 0 0
00812303 108 1000 b2 deadbeef 1008 6 06 1 deadbeef 02 1000 00 0 1008
00712623 10c 1000 cafe c3 100c 7 00 0 0 02 1000 07 cafe 100c
00730433 110 5 7 c 40 9 08 1 c 06 5 07 7 0
00128013 114 a1 b2 a2 d4 8 00 0 0 05 a1 00 0 0
00208863 118 a1 a1 c3 d4 5 00 0 0 01 a1 02 a1 0
008000ef 11c a1 b2 120 d4 3 01 1 120 00 0 00 0 0
300194f3 120 a1 b2 1800 d4 b 09 1 1800 03 a1 00 0 0
ffffffff 124 a1 b2 c3 d4 d 00 0 0 00 0 00 0 0
00000073 128 a1 b2 c3 d4 c 00 0 0 00 0 00 0 0
0ff0000f 12c a1 b2 c3 d4 a 00 0 0 00 0 00 0 0
00001517 130 a1 b2 1130 d4 2 0a 1 1130 00 0 00 0 0
00008067 134 a1 b2 138 d4 4 00 0 0 01 a1 00 0 0

//--- bench/trace_unit_tb.sv
`timescale 1ns/1ps
`include "trace_defines.svh"

`default_nettype none

module trace_unit_tb;
  import trace_pkg::*;

  localparam int N_INSTR = 14;
  localparam int N_COL   = 15;
  localparam int LIMIT   = 500;

  logic       clk;
  logic       rst_n;
  issue_t     issue;
  complete_t  complete;
  logic       credit_return;
  logic       issue_stall;
  logic       out_valid;
  trace_rec_t out_rec;

  logic [31:0] golden [N_INSTR*N_COL];
  int          cyc;
  trace_rec_t  exp_q [$];
  int          cmpl_idx_q [$];
  int          cmpl_due_q [$];
  int          last_due;
  int          cmpl_delay;
  int          owed_credits;
  int          rcv_count;
  int          rcv_base;
  int          err_base;
  bit          hold_credits;
  bit          timed_out;
  int          errors;
  int          tests_run;
  int          tests_ok;
  string       cur_test;

  trace_unit u_trace_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue         (issue),
    .complete      (complete),
    .credit_return (credit_return),
    .issue_stall   (issue_stall),
    .out_valid     (out_valid),
    .out_rec       (out_rec)
  );

  always #5 clk = ~clk;

  // mirrors the stamp counter, 0 in the first cycle out of reset
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) cyc <= 0;
    else cyc <= cyc + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // golden data and checks
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] col(int idx, int c);
    return golden[idx*N_COL + c];
  endfunction

  function automatic trace_rec_t expected_record(int idx, int stamp);
    trace_rec_t r;
    r.stamp     = 32'(stamp);
    r.pc        = col(idx, 1);
    r.instr     = col(idx, 0);
    r.op        = trace_op_e'(4'(col(idx, 6)));
    r.rd        = 5'(col(idx, 7));
    r.rd_we     = 1'(col(idx, 8));
    r.rd_value  = col(idx, 9);
    r.rs1       = 5'(col(idx, 10));
    r.rs1_value = col(idx, 11);
    r.rs2       = 5'(col(idx, 12));
    r.rs2_value = col(idx, 13);
    r.mem_addr  = col(idx, 14);
    return r;
  endfunction

  task automatic check_value(string field, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s record %0d %s: expected %h actual %h",
               cur_test, rcv_count, field, exp, act);
    end
  endtask

  task automatic report_timeout(string what);
    timed_out = 1'b1;
    errors++;
    $display("%s: timed out waiting for %s", cur_test, what);
  endtask

  task automatic check_record();
    trace_rec_t exp;
    rcv_count++;
    owed_credits++;
    if (exp_q.size() == 0) begin
      errors++;
      $display("%s: a record arrived with no instruction outstanding", cur_test);
    end else begin
      exp = exp_q.pop_front();
      check_value("stamp", exp.stamp, out_rec.stamp);
      check_value("pc", exp.pc, out_rec.pc);
      check_value("instr", exp.instr, out_rec.instr);
      check_value("op", 32'(exp.op), 32'(out_rec.op));
      check_value("rd", 32'(exp.rd), 32'(out_rec.rd));
      check_value("rd_we", 32'(exp.rd_we), 32'(out_rec.rd_we));
      check_value("rd_value", exp.rd_value, out_rec.rd_value);
      check_value("rs1", 32'(exp.rs1), 32'(out_rec.rs1));
      check_value("rs1_value", exp.rs1_value, out_rec.rs1_value);
      check_value("rs2", 32'(exp.rs2), 32'(out_rec.rs2));
      check_value("rs2_value", exp.rs2_value, out_rec.rs2_value);
      check_value("mem_addr", exp.mem_addr, out_rec.mem_addr);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // core side and sink side
  //////////////////////////////////////////////////////////////////////

  // holds the issue through any stall, then queues its completion
  task automatic issue_one(int idx);
    int n;
    int due;
    issue.valid     = 1'b1;
    issue.pc        = col(idx, 1);
    issue.instr     = col(idx, 0);
    issue.rs1_value = col(idx, 2);
    issue.rs2_value = col(idx, 3);
    n = 0;
    while (issue_stall && n < LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (issue_stall) begin
      report_timeout("issue_stall to fall");
    end else begin
      exp_q.push_back(expected_record(idx, cyc));
      due = cyc + 1 + cmpl_delay + int'($urandom % 3);
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      cmpl_idx_q.push_back(idx);
      cmpl_due_q.push_back(due);
    end
    @(posedge clk);
    #1;
    issue = '0;
  endtask

  task automatic issue_all();
    for (int i = 0; i < N_INSTR; i++) begin
      issue_one(i);
    end
  endtask

  initial begin : completion_driver
    int idx;
    complete = '0;
    forever begin
      @(posedge clk);
      #1;
      complete = '0;
      if (cmpl_idx_q.size() > 0 && cyc >= cmpl_due_q[0]) begin
        idx = cmpl_idx_q.pop_front();
        void'(cmpl_due_q.pop_front());
        complete.valid    = 1'b1;
        complete.wb_data  = col(idx, 4);
        complete.mem_addr = col(idx, 5);
      end
    end
  end

  // one credit back per cycle for each record taken, unless held
  initial begin : record_sink
    credit_return = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      credit_return = 1'b0;
      if (out_valid) check_record();
      if (!hold_credits && owed_credits > 0) begin
        credit_return = 1'b1;
        owed_credits--;
      end
    end
  end

  task automatic wait_records(int target);
    int n;
    n = 0;
    while (rcv_count < target && n < LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (rcv_count < target) report_timeout("the remaining records");
  endtask

  task automatic watch_back_pressure();
    int n;
    n = 0;
    while (!issue_stall && n < LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!issue_stall) report_timeout("issue_stall to rise");
    repeat (20) begin
      @(posedge clk);
      #1;
    end
    check_value("records without credit", `TRACE_CREDITS, 32'(rcv_count - rcv_base));
    check_value("issue_stall", 32'd1, 32'(issue_stall));
    hold_credits = 1'b0;
  endtask

  task automatic start_test(string name);
    cur_test = name;
    err_base = errors;
    rcv_base = rcv_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == err_base) begin
      tests_ok++;
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, errors - err_base);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(9));
    clk          = 1'b0;
    rst_n        = 1'b0;
    issue        = '0;
    hold_credits = 1'b0;
    timed_out    = 1'b0;
    cmpl_delay   = 0;
    last_due     = 0;
    owed_credits = 0;
    rcv_count    = 0;
    errors       = 0;
    tests_run    = 0;
    tests_ok     = 0;
    $readmemh("bench/trace_golden.txt", golden);
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test("reset_state");
    check_value("out_valid", 32'd0, 32'(out_valid));
    check_value("issue_stall", 32'd0, 32'(issue_stall));
    end_test();

    // credits held from reset, so only the initial credits can flow
    start_test("credit_back_pressure");
    hold_credits = 1'b1;
    fork
      issue_all();
      watch_back_pressure();
    join
    wait_records(rcv_base + N_INSTR);
    end_test();

    if (!timed_out) begin
      start_test("class_decode");
      cmpl_delay = 0;
      issue_all();
      wait_records(rcv_base + N_INSTR);
      end_test();
    end

    // slow completions let the whole pool fill before the first one
    if (!timed_out) begin
      start_test("burst_in_order");
      cmpl_delay = 8;
      issue_all();
      wait_records(rcv_base + N_INSTR);
      end_test();
    end

    $display("%0d of %0d tests ok, %0d errors", tests_ok, tests_run, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module trace_unit_tb \
  -f trace_unit.f \
  -o trace_unit_sim

./obj_dir/trace_unit_sim | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
if ! grep -q "all tests passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

//--- source/trace_capture.sv
`timescale 1ns/1ps
`include "trace_defines.svh"

`default_nettype none

module trace_capture (
  input  logic                     clk,
  input  logic                     rst_n,
  input  trace_pkg::issue_t        issue,
  input  trace_pkg::complete_t     complete,
  input  logic [`TRACE_SLOTS-1:0]  slot_busy,
  output logic                     issue_stall,
  output logic [`TRACE_SLOTS-1:0]  load_sel,
  output trace_pkg::trace_rec_t    slot_load,
  output logic [`TRACE_SLOTS-1:0]  complete_sel
);
  import trace_pkg::*;

  // full encodings checked as a whole
  localparam logic [31:0] INSTR_NOP    = 32'h0000_0013;
  localparam logic [31:0] INSTR_ECALL  = 32'h0000_0073;
  localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;
  localparam logic [31:0] INSTR_MRET   = 32'h3020_0073;
  localparam logic [31:0] INSTR_WFI    = 32'h1050_0073;

  logic [`TRACE_STAMP_W-1:0]    cycle_cnt;
  logic [`TRACE_SLOT_IDX_W-1:0] alloc_ptr;
  logic [`TRACE_SLOT_IDX_W-1:0] cmpl_ptr;
  logic                         accept;
  major_opcode_e                opcode;
  logic [2:0]                   funct3;
  logic [6:0]                   funct7;
  trace_op_e                    op;
  logic                         reads_rs1;
  logic                         reads_rs2;
  logic                         writes_rd;

  //////////////////////////////////////////////////////////////////////
  // counters and pointers
  //////////////////////////////////////////////////////////////////////

  assign issue_stall = slot_busy[alloc_ptr];
  assign accept      = issue.valid && !issue_stall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
      alloc_ptr <= '0;
      cmpl_ptr  <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
      if (accept) alloc_ptr <= alloc_ptr + 1'b1;
      // completions come back in issue order
      if (complete.valid) cmpl_ptr <= cmpl_ptr + 1'b1;
    end
  end

  always_comb begin
    for (int i = 0; i < `TRACE_SLOTS; i++) begin
      load_sel[i]     = accept && (alloc_ptr == `TRACE_SLOT_IDX_W'(i));
      complete_sel[i] = complete.valid && (cmpl_ptr == `TRACE_SLOT_IDX_W'(i));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // class decode
  //////////////////////////////////////////////////////////////////////

  assign funct3 = issue.instr[14:12];
  assign funct7 = issue.instr[31:25];

  always_comb begin
    opcode    = major_opcode_e'(issue.instr[6:0]);
    op        = INVALID;
    reads_rs1 = 1'b0;
    reads_rs2 = 1'b0;
    writes_rd = 1'b0;
    case (opcode)
      OPC_LUI: begin op = LUI; writes_rd = 1'b1; end
      OPC_AUIPC: begin op = AUIPC; writes_rd = 1'b1; end
      OPC_JAL: begin op = JAL; writes_rd = 1'b1; end
      OPC_JALR: if (funct3 == 3'b000) begin
        op = JALR; reads_rs1 = 1'b1; writes_rd = 1'b1;
      end
      // funct3 010 and 011 are unused
      OPC_BRANCH: if (funct3[2:1] != 2'b01) begin
        op = BRANCH; reads_rs1 = 1'b1; reads_rs2 = 1'b1;
      end
      OPC_LOAD: if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
        op = LOAD; reads_rs1 = 1'b1; writes_rd = 1'b1;
      end
      OPC_STORE: if (!funct3[2] && funct3[1:0] != 2'b11) begin
        op = STORE; reads_rs1 = 1'b1; reads_rs2 = 1'b1;
      end
      OPC_OP_IMM: begin
        if (issue.instr == INSTR_NOP) begin
          op = NOP;
        end else if (!(funct3 == 3'b001 && funct7 != 7'h00) &&
                     !(funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20)) begin
          op = OPIMM; reads_rs1 = 1'b1; writes_rd = 1'b1;
        end
      end
      // sub and sra are the only funct7 variants
      OPC_OP: if (funct7 == 7'h00 ||
                  (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
        op = OP; reads_rs1 = 1'b1; reads_rs2 = 1'b1; writes_rd = 1'b1;
      end
      OPC_MISC_MEM: if (funct3[2:1] == 2'b00) op = FENCE;
      OPC_SYSTEM: begin
        if (funct3 == 3'b000) begin
          if (issue.instr == INSTR_ECALL || issue.instr == INSTR_EBREAK ||
              issue.instr == INSTR_MRET || issue.instr == INSTR_WFI) op = PRIV;
        end else if (funct3 != 3'b100) begin
          // immediate forms carry uimm in the rs1 field
          op = CSR; reads_rs1 = !funct3[2]; writes_rd = 1'b1;
        end
      end
      default: op = INVALID;
    endcase
  end

  always_comb begin
    slot_load           = '0;
    slot_load.stamp     = cycle_cnt;
    slot_load.pc        = issue.pc;
    slot_load.instr     = issue.instr;
    slot_load.op        = op;
    slot_load.rs1       = reads_rs1 ? issue.instr[19:15] : '0;
    slot_load.rs1_value = reads_rs1 ? issue.rs1_value : '0;
    slot_load.rs2       = reads_rs2 ? issue.instr[24:20] : '0;
    slot_load.rs2_value = reads_rs2 ? issue.rs2_value : '0;
    slot_load.rd        = writes_rd ? issue.instr[11:7] : '0;
    // x0 is never reported as written
    slot_load.rd_we     = writes_rd && (issue.instr[11:7] != '0);
  end

endmodule

`default_nettype wire

//--- source/trace_defines.svh
`ifndef TRACE_DEFINES_SVH
`define TRACE_DEFINES_SVH

`default_nettype none

// data and address width
`define TRACE_XLEN 32

// register index width
`define TRACE_REG_AW 5

// tracking slot pool, must stay a power of two
`define TRACE_SLOTS 4
`define TRACE_SLOT_IDX_W 2

// sink credits held after reset
`define TRACE_CREDITS 2

// cycle stamp width
`define TRACE_STAMP_W 32

`default_nettype wire

`endif

//--- source/trace_emitter.sv
`timescale 1ns/1ps
`include "trace_defines.svh"

`default_nettype none

module trace_emitter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`TRACE_SLOTS-1:0] slot_ready,
  input  trace_pkg::trace_rec_t   slot_rec [`TRACE_SLOTS],
  input  logic                    credit_return,
  output logic [`TRACE_SLOTS-1:0] drain_sel,
  output logic                    out_valid,
  output trace_pkg::trace_rec_t   out_rec
);

  localparam int CRED_W = $clog2(`TRACE_CREDITS + 1);

  logic [`TRACE_SLOT_IDX_W-1:0] drain_ptr;
  logic [CRED_W-1:0]            credits;
  logic                         send;

  // oldest slot goes out once it is ready and a credit is held
  assign send = slot_ready[drain_ptr] && (credits != '0);

  always_comb begin
    for (int i = 0; i < `TRACE_SLOTS; i++) begin
      drain_sel[i] = send && (drain_ptr == `TRACE_SLOT_IDX_W'(i));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pointer and credit counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drain_ptr <= '0;
      credits   <= CRED_W'(`TRACE_CREDITS);
      out_valid <= 1'b0;
    end else begin
      out_valid <= send;
      if (send) drain_ptr <= drain_ptr + 1'b1;
      // a return in the same cycle as a send leaves the count alone
      case ({send, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output record
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (send) begin
      out_rec <= slot_rec[drain_ptr];
    end
  end

endmodule

`default_nettype wire

//--- source/trace_pkg.sv
`include "trace_defines.svh"

`default_nettype none

package trace_pkg;

  // rv32i major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'h03,
    OPC_MISC_MEM = 7'h0f,
    OPC_OP_IMM   = 7'h13,
    OPC_AUIPC    = 7'h17,
    OPC_STORE    = 7'h23,
    OPC_OP       = 7'h33,
    OPC_LUI      = 7'h37,
    OPC_BRANCH   = 7'h63,
    OPC_JALR     = 7'h67,
    OPC_JAL      = 7'h6f,
    OPC_SYSTEM   = 7'h73
  } major_opcode_e;

  // trace classes reported in each record
  typedef enum logic [3:0] {
    NOP, LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE,
    OPIMM, OP, FENCE, CSR, PRIV, INVALID
  } trace_op_e;

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    READY
  } slot_state_e;

  typedef struct packed {
    logic                   valid;
    logic [`TRACE_XLEN-1:0] pc;
    logic [31:0]            instr;
    logic [`TRACE_XLEN-1:0] rs1_value;
    logic [`TRACE_XLEN-1:0] rs2_value;
  } issue_t;

  typedef struct packed {
    logic                   valid;
    logic [`TRACE_XLEN-1:0] wb_data;
    logic [`TRACE_XLEN-1:0] mem_addr;
  } complete_t;

  typedef struct packed {
    logic [`TRACE_STAMP_W-1:0] stamp;
    logic [`TRACE_XLEN-1:0]    pc;
    logic [31:0]               instr;
    trace_op_e                 op;
    logic [`TRACE_REG_AW-1:0]  rs1;
    logic [`TRACE_XLEN-1:0]    rs1_value;
    logic [`TRACE_REG_AW-1:0]  rs2;
    logic [`TRACE_XLEN-1:0]    rs2_value;
    logic [`TRACE_REG_AW-1:0]  rd;
    logic                      rd_we;
    logic [`TRACE_XLEN-1:0]    rd_value;
    logic [`TRACE_XLEN-1:0]    mem_addr;
  } trace_rec_t;

endpackage

`default_nettype wire

//--- source/trace_slot.sv
`timescale 1ns/1ps
`include "trace_defines.svh"

`default_nettype none

module trace_slot (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  load,
  input  trace_pkg::trace_rec_t load_rec,
  input  logic                  complete_en,
  input  trace_pkg::complete_t  complete,
  input  logic                  drain,
  output logic                  busy,
  output logic                  ready,
  output trace_pkg::trace_rec_t rec
);
  import trace_pkg::*;

  slot_state_e state;
  logic        is_mem;

  //////////////////////////////////////////////////////////////////////
  // slot state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (load) state <= WAIT;
        WAIT:    if (complete_en) state <= READY;
        READY:   if (drain) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  assign busy  = (state != IDLE);
  assign ready = (state == READY);

  //////////////////////////////////////////////////////////////////////
  // record storage
  //////////////////////////////////////////////////////////////////////

  assign is_mem = (rec.op == LOAD) || (rec.op == STORE);

  always_ff @(posedge clk) begin
    if (load) begin
      rec <= load_rec;
    end else if (complete_en) begin
      // merge completion data into the held record
      rec.rd_value <= rec.rd_we ? complete.wb_data : '0;
      rec.mem_addr <= is_mem ? complete.mem_addr : '0;
    end
  end

endmodule

`default_nettype wire

//--- source/trace_unit.sv
`timescale 1ns/1ps
`include "trace_defines.svh"

`default_nettype none

module trace_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  trace_pkg::issue_t     issue,
  input  trace_pkg::complete_t  complete,
  input  logic                  credit_return,
  output logic                  issue_stall,
  output logic                  out_valid,
  output trace_pkg::trace_rec_t out_rec
);
  import trace_pkg::*;

  logic [`TRACE_SLOTS-1:0] load_sel;
  logic [`TRACE_SLOTS-1:0] complete_sel;
  logic [`TRACE_SLOTS-1:0] drain_sel;
  logic [`TRACE_SLOTS-1:0] slot_busy;
  logic [`TRACE_SLOTS-1:0] slot_ready;
  trace_rec_t              slot_load;
  trace_rec_t              slot_rec [`TRACE_SLOTS];

  trace_capture u_capture (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue        (issue),
    .complete     (complete),
    .slot_busy    (slot_busy),
    .issue_stall  (issue_stall),
    .load_sel     (load_sel),
    .slot_load    (slot_load),
    .complete_sel (complete_sel)
  );

  // slot pool, filled round robin by capture and drained in the same order
  for (genvar g = 0; g < `TRACE_SLOTS; g++) begin : g_slot
    trace_slot u_slot (
      .clk         (clk),
      .rst_n       (rst_n),
      .load        (load_sel[g]),
      .load_rec    (slot_load),
      .complete_en (complete_sel[g]),
      .complete    (complete),
      .drain       (drain_sel[g]),
      .busy        (slot_busy[g]),
      .ready       (slot_ready[g]),
      .rec         (slot_rec[g])
    );
  end

  trace_emitter u_emitter (
    .clk           (clk),
    .rst_n         (rst_n),
    .slot_ready    (slot_ready),
    .slot_rec      (slot_rec),
    .credit_return (credit_return),
    .drain_sel     (drain_sel),
    .out_valid     (out_valid),
    .out_rec       (out_rec)
  );

endmodule

`default_nettype wire

//--- trace_unit.f
+incdir+source
source/trace_pkg.sv
source/trace_capture.sv
source/trace_slot.sv
source/trace_emitter.sv
source/trace_unit.sv
bench/trace_unit_tb.sv
